//--- Makefile
# Verilator build and run of the instruction cache testbench.

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ####################
// Address geometry
// ####################

`define ICACHE_ADDR_W   32
`define ICACHE_OFFSET_W 5
`define ICACHE_INDEX_W  4
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_OFFSET_W - `ICACHE_INDEX_W)

// ####################
// Array geometry
// ####################

`define ICACHE_LINE_W   256
`define ICACHE_SETS     16
`define ICACHE_WAYS     2   // One PLRU bit per set only covers two ways.

`endif

//--- hdl/icache_control.sv
`default_nettype none

module icache_control
    import icache_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,

    input  wire logic mem_read,
    input  wire logic mem_cancel,
    input  wire logic lookup_hit,
    input  wire logic fill_done,

    output logic      capture,
    output logic      plru_touch,
    output logic      line_install,
    output logic      fill_start,

    output logic      mem_resp,
    output logic      hit,
    output logic      miss
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        cancelled_q;
    logic        cancel_now;

    // ####################
    // Next state
    // ####################

    assign cancel_now = cancelled_q || mem_cancel;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (mem_read)
                    state_d = COMPARE;
            end
            COMPARE: begin
                state_d = lookup_hit ? IDLE : FILL;
            end
            FILL: begin
                if (fill_done)
                    state_d = REFILL;
            end
            REFILL: begin
                // A cancelled request leaves the installed line behind silently.
                state_d = cancel_now ? IDLE : COMPARE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= IDLE;
            cancelled_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture)
                cancelled_q <= 1'b0;
            else if ((state_q == FILL || state_q == REFILL) && mem_cancel)
                cancelled_q <= 1'b1;
        end
    end

    // ####################
    // Outputs
    // ####################

    assign capture      = (state_q == IDLE) && mem_read;
    assign line_install = (state_q == FILL) && fill_done;

    always_comb begin
        mem_resp   = 1'b0;
        hit        = 1'b0;
        miss       = 1'b0;
        plru_touch = 1'b0;
        fill_start = 1'b0;
        if (state_q == COMPARE) begin
            mem_resp   = lookup_hit;
            hit        = lookup_hit;
            plru_touch = lookup_hit;
            miss       = !lookup_hit;
            fill_start = !lookup_hit;   // pmem_read follows on the next cycle.
        end
    end

endmodule : icache_control

`default_nettype wire

//--- hdl/icache_data_array.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_data_array
    import icache_pkg::*;
(
    input  wire logic   clk,

    input  wire index_t lookup_index,
    input  wire index_t write_index,

    input  wire logic   line_install,
    input  wire way_t   install_way,
    input  wire line_t  fill_line,

    input  wire way_t   read_way,
    output line_t       mem_rdata
);

    line_t rdata_q [`ICACHE_WAYS];

    // ####################
    // Line storage
    // ####################

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        line_t mem [`ICACHE_SETS];

        // A read in the same cycle as a write returns the old line.
        always_ff @(posedge clk) begin
            if (line_install && (install_way == way_t'(w)))
                mem[write_index] <= fill_line;
            rdata_q[w] <= mem[lookup_index];
        end
    end

    assign mem_rdata = rdata_q[read_way];   // Only meaningful on a hit.

endmodule : icache_data_array

`default_nettype wire

//--- hdl/icache_fill_port.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_fill_port
    import icache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,

    input  wire req_t  req,
    input  wire logic  fill_start,

    output addr_t      pmem_address,
    output logic       pmem_read,
    input  wire line_t pmem_rdata,
    input  wire logic  pmem_resp,

    output logic       fill_done,
    output line_t      fill_line
);

    // The latched request is stable for the whole miss, so the address needs no register.
    assign pmem_address = {req.tag, req.index, {`ICACHE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pmem_read <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= pmem_read && pmem_resp;
            if (fill_start)
                pmem_read <= 1'b1;
            else if (pmem_resp)
                pmem_read <= 1'b0;  // Held through any memory stall.
        end
    end

    always_ff @(posedge clk) begin
        if (pmem_read && pmem_resp)
            fill_line <= pmem_rdata;
    end

endmodule : icache_fill_port

`default_nettype wire

//--- hdl/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic                       way_t;

    // Control sequence of a single request.
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        FILL,
        REFILL
    } ctrl_state_t;

    // The part of a CPU address that stays with the request.
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } req_t;

endpackage : icache_pkg

`default_nettype wire

//--- hdl/icache_req_latch.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_req_latch
    import icache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,

    input  wire addr_t  mem_address,
    input  wire logic   capture,

    output req_t        req,
    output index_t      lookup_index
);

    index_t in_index;
    tag_t   in_tag;

    assign in_index = mem_address[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign in_tag   = mem_address[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    // The request stays put until the FSM is back in IDLE.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req <= '0;
        end else if (capture) begin
            req.tag   <= in_tag;
            req.index <= in_index;
        end
    end

    // Arrays are synchronous, so the set goes out a cycle ahead of the compare.
    assign lookup_index = capture ? in_index : req.index;

endmodule : icache_req_latch

`default_nettype wire

//--- hdl/icache_tag_array.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_tag_array
    import icache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,

    input  wire index_t lookup_index,
    input  wire req_t   req,

    input  wire logic   plru_touch,
    input  wire logic   line_install,
    input  wire way_t   install_way,

    output logic        lookup_hit,
    output way_t        hit_way,
    output way_t        victim_way
);

    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
    logic [`ICACHE_SETS-1:0]                   plru_q;  // Names the way to evict next.
    tag_t                                      tag_q [`ICACHE_SETS][`ICACHE_WAYS];

    index_t                  rd_index_q;
    logic [`ICACHE_WAYS-1:0] rd_valid;
    logic [`ICACHE_WAYS-1:0] way_hit;

    // ####################
    // State update
    // ####################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_index_q <= '0;
            valid_q    <= '0;
            plru_q     <= '0;
        end else begin
            rd_index_q <= lookup_index;
            if (line_install) begin
                valid_q[req.index][install_way] <= 1'b1;
                plru_q[req.index]               <= ~install_way;
            end else if (plru_touch) begin
                plru_q[req.index] <= ~hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_install)
            tag_q[req.index][install_way] <= req.tag;
    end

    // ####################
    // Lookup
    // ####################

    assign rd_valid = valid_q[rd_index_q];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = rd_valid[w] && (tag_q[rd_index_q][w] == req.tag);
            if (way_hit[w])
                hit_way = way_t'(w);
        end
    end

    assign lookup_hit = |way_hit;

    // Fill an empty way before displacing anything.
    always_comb begin
        if (!rd_valid[0])
            victim_way = 1'b0;
        else if (!rd_valid[1])
            victim_way = 1'b1;
        else
            victim_way = plru_q[rd_index_q];
    end

endmodule : icache_tag_array

`default_nettype wire

//--- hdl/icache_top.sv
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,

    // CPU side.
    input  wire addr_t mem_address,
    input  wire logic  mem_read,
    input  wire logic  mem_cancel,
    output line_t      mem_rdata,
    output logic       mem_resp,

    // Memory side.
    output addr_t      pmem_address,
    output logic       pmem_read,
    input  wire line_t pmem_rdata,
    input  wire logic  pmem_resp,

    output logic       hit,
    output logic       miss
);

    req_t   req;
    index_t lookup_index;
    logic   capture;
    logic   lookup_hit;
    way_t   hit_way;
    way_t   victim_way;
    logic   plru_touch;
    logic   line_install;
    logic   fill_start;
    logic   fill_done;
    line_t  fill_line;

    icache_req_latch i_req_latch (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_address  (mem_address),
        .capture      (capture),
        .req          (req),
        .lookup_index (lookup_index)
    );

    icache_control i_control (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_cancel   (mem_cancel),
        .lookup_hit   (lookup_hit),
        .fill_done    (fill_done),
        .capture      (capture),
        .plru_touch   (plru_touch),
        .line_install (line_install),
        .fill_start   (fill_start),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .miss         (miss)
    );

    // The victim stays stable through FILL, so it doubles as the install way.
    icache_tag_array i_tag_array (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup_index (lookup_index),
        .req          (req),
        .plru_touch   (plru_touch),
        .line_install (line_install),
        .install_way  (victim_way),
        .lookup_hit   (lookup_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way)
    );

    icache_data_array i_data_array (
        .clk          (clk),
        .lookup_index (lookup_index),
        .write_index  (req.index),
        .line_install (line_install),
        .install_way  (victim_way),
        .fill_line    (fill_line),
        .read_way     (hit_way),
        .mem_rdata    (mem_rdata)
    );

    icache_fill_port i_fill_port (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .fill_start   (fill_start),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .fill_done    (fill_done),
        .fill_line    (fill_line)
    );

endmodule : icache_top

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_req_latch.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_control.sv
hdl/icache_fill_port.sv
hdl/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

//--- verif/icache_mem_model.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_mem_model
    import icache_pkg::*;
#(
    parameter logic [31:0] WORD_KEY = 32'h0
) (
    input  wire logic  clk,
    input  wire logic  arst_n,

    input  wire addr_t pmem_address,
    input  wire logic  pmem_read,
    output line_t      pmem_rdata,
    output logic       pmem_resp
);

    timeunit 1ns;
    timeprecision 1ps;

    integer seed       = 89;
    logic   busy       = 1'b0;
    logic   resp_q     = 1'b0;
    line_t  rdata_q    = '0;
    int     delay_left = 0;

    // Every word holds its own word address mixed with a key.
    function automatic line_t pattern_line(input addr_t addr);
        line_t data;
        addr_t word_addr;
        word_addr = {2'b00, addr[`ICACHE_ADDR_W-1:2]} & ~addr_t'(7);
        for (int w = 0; w < `ICACHE_LINE_W / 32; w++)
            data[w*32 +: 32] = (word_addr + addr_t'(w)) ^ WORD_KEY;
        return data;
    endfunction

    assign pmem_resp  = resp_q;
    assign pmem_rdata = rdata_q;

    always @(negedge clk) begin
        if (!arst_n) begin
            busy       = 1'b0;
            resp_q     = 1'b0;
            delay_left = 0;
        end else if (resp_q) begin
            resp_q = 1'b0;  // The response lasts one cycle.
            busy   = 1'b0;
        end else if (busy) begin
            delay_left--;
            if (delay_left == 0) begin
                resp_q  = 1'b1;
                rdata_q = pattern_line(pmem_address);
            end
        end else if (pmem_read) begin
            busy       = 1'b1;
            delay_left = 1 + int'($unsigned($random(seed)) % 6);
        end
    end

endmodule : icache_mem_model

`default_nettype wire

//--- verif/icache_tb.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_tb
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] WORD_KEY        = 32'h9E37_79B9;
    localparam int          RANDOM_READS    = 300;
    localparam int          NUM_REQUESTS    = RANDOM_READS + 20;
    localparam int          MAX_MISS_CYCLES = 16;  // Compare, fill, up to six memory cycles, refill.
    localparam int          TIMEOUT_CYCLES  = NUM_REQUESTS * MAX_MISS_CYCLES + 200;

    typedef struct packed {
        logic  miss;
        line_t data;
    } expect_t;

    logic  clk = 1'b0;
    logic  arst_n;
    addr_t mem_address;
    logic  mem_read;
    logic  mem_cancel;
    line_t mem_rdata;
    logic  mem_resp;
    addr_t pmem_address;
    logic  pmem_read;
    line_t pmem_rdata;
    logic  pmem_resp;
    logic  hit;
    logic  miss;

    logic [`ICACHE_WAYS-1:0] ref_valid [`ICACHE_SETS];
    tag_t                    ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    way_t                    ref_plru  [`ICACHE_SETS];

    expect_t expected_q [$];
    expect_t head;
    addr_t   cur_line_addr;
    logic    miss_seen;
    int      hit_count;
    int      reads_done;
    int      cycle_count = 0;
    integer  rand_seed;

    always #4 clk = ~clk;

    icache_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_address  (mem_address),
        .mem_read     (mem_read),
        .mem_cancel   (mem_cancel),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .hit          (hit),
        .miss         (miss)
    );

    icache_mem_model #(.WORD_KEY(WORD_KEY)) i_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    // ####################
    // Reporting
    // ####################

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input line_t actual, input line_t expected);
        if (actual !== expected)
            stop_run($sformatf("FAIL at %0t ns: %s is %0h, expected %0h",
                               $time, name, actual, expected));
    endtask

    // ####################
    // Reference model
    // ####################

    function automatic addr_t line_base(input addr_t addr);
        return {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic line_t line_of(input addr_t addr);
        line_t result;
        addr_t base;
        base = line_base(addr);
        for (int w = 0; w < `ICACHE_LINE_W / 32; w++)
            result[w*32 +: 32] = ((base + addr_t'(4 * w)) >> 2) ^ WORD_KEY;
        return result;
    endfunction

    // Looks the address up, installs it on a miss and returns whether it missed.
    function automatic logic predict_miss(input addr_t addr);
        tag_t   t;
        index_t s;
        logic   found;
        way_t   victim;
        t     = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        s     = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        found = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                found       = 1'b1;
                ref_plru[s] = ~way_t'(w);
            end
        end
        if (!found) begin
            if (!ref_valid[s][0])
                victim = 1'b0;
            else if (!ref_valid[s][1])
                victim = 1'b1;
            else
                victim = ref_plru[s];
            ref_valid[s][victim] = 1'b1;
            ref_tag[s][victim]   = t;
            ref_plru[s]          = ~victim;  // The closing hit touches the same way.
        end
        return !found;
    endfunction

    // ####################
    // Stimulus tasks
    // ####################

    task automatic issue_read(input addr_t addr);
        expect_t item;
        int      waited;
        item.miss = predict_miss(addr);
        item.data = line_of(addr);
        expected_q.push_back(item);
        cur_line_addr = line_base(addr);
        mem_address   = addr;
        mem_read      = 1'b1;
        waited        = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!mem_resp);
        mem_read = 1'b0;
        if (!item.miss)
            check_value("hit latency", line_t'(waited), line_t'(1));
        @(negedge clk);  // One idle cycle so the next capture happens in IDLE.
        reads_done++;
        // Every answered read ends in exactly one hit pulse.
        check_value("hit count", line_t'(hit_count), line_t'(reads_done));
    endtask

    task automatic cancelled_read(input addr_t addr);
        logic will_miss;
        will_miss = predict_miss(addr);
        if (!will_miss)
            stop_run("The cancel address is already cached, so no fill would start.");
        cur_line_addr = line_base(addr);
        mem_address   = addr;
        mem_read      = 1'b1;
        do begin
            @(negedge clk);
        end while (!pmem_read);
        mem_read   = 1'b0;
        mem_cancel = 1'b1;
        @(negedge clk);
        mem_cancel = 1'b0;
        while (pmem_read)
            @(negedge clk);
        repeat (2) @(negedge clk);  // REFILL, then IDLE.
        check_value("miss", line_t'(miss_seen), line_t'(1));
        check_value("hit count", line_t'(hit_count), line_t'(reads_done));
        miss_seen = 1'b0;
    endtask

    // ####################
    // Compare and timeout
    // ####################

    always @(negedge clk) begin
        if (arst_n) begin
            if (hit)
                hit_count++;
            if (pmem_read)
                check_value("pmem_address", line_t'(pmem_address), line_t'(cur_line_addr));
            if (miss)
                miss_seen = 1'b1;
            if (mem_resp) begin
                if (expected_q.size() == 0) begin
                    stop_run("mem_resp arrived with no read outstanding.");
                end else begin
                    head = expected_q.pop_front();
                    check_value("hit", line_t'(hit), line_t'(1));
                    check_value("miss", line_t'(miss_seen), line_t'(head.miss));
                    check_value("mem_rdata", mem_rdata, head.data);
                    miss_seen = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            stop_run($sformatf("Timeout: the tests did not end within %0d cycles.",
                               TIMEOUT_CYCLES));
    end

    initial begin
        addr_t addr;
        int    r;
        arst_n        = 1'b0;
        mem_read      = 1'b0;
        mem_cancel    = 1'b0;
        mem_address   = '0;
        cur_line_addr = '0;
        miss_seen     = 1'b0;
        hit_count     = 0;
        reads_done    = 0;
        rand_seed     = 89;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_valid[s] = '0;
            ref_plru[s]  = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++)
                ref_tag[s][w] = '0;
        end

        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("mem_resp", line_t'(mem_resp), '0);
        check_value("hit", line_t'(hit), '0);
        check_value("miss", line_t'(miss), '0);
        check_value("pmem_read", line_t'(pmem_read), '0);

        issue_read(32'h0000_1040);  // Cold miss, then the same line hits.
        issue_read(32'h0000_1040);

        // Three tags fighting over set 5.
        issue_read(32'h0001_00A0);
        issue_read(32'h0002_00A0);
        issue_read(32'h0001_00A0);
        issue_read(32'h0003_00A0);
        issue_read(32'h0002_00A0);

        issue_read(32'h0000_2064);
        issue_read(32'h0000_207C);
        issue_read(32'h0000_2060);

        cancelled_read(32'h0004_0180);
        issue_read(32'h0004_0180);

        // Four tags over four sets keep both hits and evictions frequent.
        repeat (RANDOM_READS) begin
            r    = $random(rand_seed);
            addr = {tag_t'(r[1:0]) + tag_t'(8), index_t'(r[3:2]), r[8:4]};
            issue_read(addr);
        end

        repeat (4) @(negedge clk);
        if (expected_q.size() != 0) begin
            stop_run("Some reads never got a response.");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule : icache_tb

`default_nettype wire
